/* design/cpu_block_defines.svh */
`ifndef CPU_BLOCK_DEFINES_SVH
`define CPU_BLOCK_DEFINES_SVH

// number of worker cells in the block
`define CPU_QUANTITY 4

// memory word address width
`define ADDR_SIZE 16

// memory word and running sum width
`define DATA_SIZE 32

// job word count width
`define LEN_SIZE 8

`endif

/* design/cpu_block_pkg.sv */
`include "cpu_block_defines.svh"

package cpu_block_pkg;

  typedef logic [`ADDR_SIZE-1:0] addr_t;             // word address
  typedef logic [`DATA_SIZE-1:0] data_t;             // word or sum
  typedef logic [`LEN_SIZE-1:0] len_t;               // words per job
  typedef logic [$clog2(`CPU_QUANTITY)-1:0] cell_idx_t;
  typedef logic [`CPU_QUANTITY-1:0] cell_mask_t;     // one bit per cell

  // worker cell FSM
  typedef enum logic [2:0] {
    CELL_IDLE,
    CELL_READ_REQ,    // read request out, waiting for grant
    CELL_READ_WAIT,   // read granted, waiting for data
    CELL_WRITE_REQ,   // sum write out, waiting for grant
    CELL_REPORT       // sum on result port
  } cell_state_e;

  // round-robin pick, nearest requester after last, last itself lowest
  function automatic cell_idx_t rr_pick(cell_mask_t req, cell_idx_t last);
    cell_idx_t pick;
    cell_idx_t cand;
    pick = last;
    for (int k = `CPU_QUANTITY; k >= 1; k--) begin
      cand = cell_idx_t'((int'(last) + k) % `CPU_QUANTITY);
      if (req[cand]) pick = cand; // smaller distance wins, checked last
    end
    return pick;
  endfunction

endpackage

/* design/cpu_cell.sv */
`timescale 1ns/1ns

module cpu_cell (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,      // one cycle, cell is idle
  input  cpu_block_pkg::addr_t  base,
  input  cpu_block_pkg::len_t   len,
  input  logic                  gnt,        // request taken by arbiter
  input  logic                  rsp_valid,  // read data for this cell
  input  cpu_block_pkg::data_t  rsp_data,
  input  logic                  res_ready,
  output logic                  busy,
  output logic                  req_valid,
  output logic                  req_we,
  output cpu_block_pkg::addr_t  req_addr,
  output cpu_block_pkg::data_t  req_wdata,
  output logic                  res_valid,
  output cpu_block_pkg::data_t  res_sum
);

  import cpu_block_pkg::*;

  cell_state_e state_q;
  len_t        cnt_q;   // words read so far
  len_t        cnt_nxt;
  addr_t       base_q;
  len_t        len_q;
  data_t       sum_q;   // running sum

  assign cnt_nxt = cnt_q + len_t'(1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= CELL_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        CELL_IDLE: begin
          if (start) begin
            cnt_q <= '0;
            // empty job goes straight to the write of a zero sum
            state_q <= (len == '0) ? CELL_WRITE_REQ : CELL_READ_REQ;
          end
        end
        CELL_READ_REQ: begin
          if (gnt) state_q <= CELL_READ_WAIT; // one read outstanding
        end
        CELL_READ_WAIT: begin
          if (rsp_valid) begin
            cnt_q   <= cnt_nxt;
            state_q <= (cnt_nxt == len_q) ? CELL_WRITE_REQ : CELL_READ_REQ;
          end
        end
        CELL_WRITE_REQ: begin
          if (gnt) state_q <= CELL_REPORT; // write done at grant
        end
        CELL_REPORT: begin
          if (res_ready) state_q <= CELL_IDLE;
        end
        default: state_q <= CELL_IDLE;
      endcase
    end
  end

  // job payload
  always_ff @(posedge clk) begin
    if (state_q == CELL_IDLE && start) begin
      base_q <= base;
      len_q  <= len;
      sum_q  <= '0;
    end else if (state_q == CELL_READ_WAIT && rsp_valid) begin
      sum_q <= sum_q + rsp_data; // accumulate, wraps at data width
    end
  end

  assign busy      = (state_q != CELL_IDLE); // report counts as busy
  assign req_valid = (state_q == CELL_READ_REQ) || (state_q == CELL_WRITE_REQ);
  assign req_we    = (state_q == CELL_WRITE_REQ);
  // reads walk base..base+len-1, sum lands at base+len
  assign req_addr  = base_q + addr_t'(req_we ? len_q : cnt_q);
  assign req_wdata = sum_q;
  assign res_valid = (state_q == CELL_REPORT);
  assign res_sum   = sum_q;

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/1ns
`include "cpu_block_defines.svh"

module bus_arbiter (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  cpu_block_pkg::cell_mask_t                    req_valid,
  input  cpu_block_pkg::cell_mask_t                    req_we,
  input  cpu_block_pkg::addr_t [`CPU_QUANTITY-1:0]     req_addr,
  input  cpu_block_pkg::data_t [`CPU_QUANTITY-1:0]     req_wdata,
  input  logic                                         mem_ready,
  input  logic                                         mem_rsp_valid,
  input  cpu_block_pkg::data_t                         mem_rsp_data,
  output cpu_block_pkg::cell_mask_t                    gnt,
  output cpu_block_pkg::cell_mask_t                    rsp_valid,
  output cpu_block_pkg::data_t                         rsp_data,
  output logic                                         mem_valid,
  output logic                                         mem_we,
  output cpu_block_pkg::addr_t                         mem_addr,
  output cpu_block_pkg::data_t                         mem_wdata
);

  import cpu_block_pkg::*;

  logic      issue_q;  // owner request on the memory port
  logic      pend_q;   // read accepted, data not back yet
  cell_idx_t owner_q;  // current owner, or last one when free
  logic      free;

  assign free = !issue_q && !pend_q; // single transaction in flight

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_q <= 1'b0;
      pend_q  <= 1'b0;
      owner_q <= '0;
    end else begin
      if (free && |req_valid) begin
        issue_q <= 1'b1;
        owner_q <= rr_pick(req_valid, owner_q); // start after last owner
      end
      if (issue_q && mem_ready) begin
        issue_q <= 1'b0;
        pend_q  <= !req_we[owner_q]; // writes finish here
      end
      if (pend_q && mem_rsp_valid) pend_q <= 1'b0;
    end
  end

  // owner holds its request until grant so the port stays stable
  assign mem_valid = issue_q;
  assign mem_we    = req_we[owner_q];
  assign mem_addr  = req_addr[owner_q];
  assign mem_wdata = req_wdata[owner_q];

  always_comb begin
    for (int k = 0; k < `CPU_QUANTITY; k++) begin
      gnt[k]       = issue_q && mem_ready && (owner_q == cell_idx_t'(k));
      rsp_valid[k] = pend_q && mem_rsp_valid && (owner_q == cell_idx_t'(k));
    end
  end

  assign rsp_data = mem_rsp_data; // shared, qualified by rsp_valid

endmodule

/* design/job_dispatcher.sv */
`timescale 1ns/1ns
`include "cpu_block_defines.svh"

module job_dispatcher (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  logic                                         job_valid,
  input  cpu_block_pkg::addr_t                         job_base,
  input  cpu_block_pkg::len_t                          job_len,
  input  cpu_block_pkg::cell_mask_t                    enable,
  input  cpu_block_pkg::cell_mask_t                    busy,
  input  cpu_block_pkg::cell_mask_t                    res_valid,
  input  cpu_block_pkg::data_t [`CPU_QUANTITY-1:0]     res_sum,
  input  logic                                         done_ready,
  output logic                                         job_ready,
  output cpu_block_pkg::cell_mask_t                    start,
  output cpu_block_pkg::addr_t [`CPU_QUANTITY-1:0]     base,
  output cpu_block_pkg::len_t [`CPU_QUANTITY-1:0]      len,
  output cpu_block_pkg::cell_mask_t                    res_ready,
  output logic                                         done_valid,
  output cpu_block_pkg::cell_idx_t                     done_cell,
  output cpu_block_pkg::data_t                         done_sum
);

  import cpu_block_pkg::*;

  logic       init_q;      // low for the first cycle out of reset
  cell_mask_t start_q;
  addr_t      base_q;
  len_t       len_q;
  cell_mask_t free_w;      // enabled, idle, no start pending
  cell_idx_t  first_free;
  cell_idx_t  last_q;      // last cell whose result was taken
  logic       hold_q;      // offered result not taken yet
  cell_idx_t  hold_idx_q;
  cell_idx_t  done_idx;

  always_comb begin
    free_w     = enable & ~busy & ~start_q; // started cell not busy for a cycle
    first_free = '0;
    for (int k = `CPU_QUANTITY - 1; k >= 0; k--) begin
      if (free_w[k]) first_free = cell_idx_t'(k); // lowest index wins
    end
  end

  assign job_ready = init_q && |free_w;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      init_q  <= 1'b0;
      start_q <= '0;
    end else begin
      init_q  <= 1'b1;
      start_q <= '0; // pulse
      if (job_valid && job_ready) start_q[first_free] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (job_valid && job_ready) begin
      base_q <= job_base;
      len_q  <= job_len;
    end
  end

  assign start = start_q;

  always_comb begin
    for (int k = 0; k < `CPU_QUANTITY; k++) begin
      base[k] = base_q; // only the started cell latches it
      len[k]  = len_q;
    end
  end

  // result side, choice frozen while the port is stalled
  assign done_idx   = hold_q ? hold_idx_q : rr_pick(res_valid, last_q);
  assign done_valid = |res_valid;
  assign done_cell  = done_idx;
  assign done_sum   = res_sum[done_idx];

  always_comb begin
    for (int k = 0; k < `CPU_QUANTITY; k++) begin
      res_ready[k] = done_ready && res_valid[k] && (done_idx == cell_idx_t'(k));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_q <= 1'b0;
      last_q <= '0;
    end else if (done_valid && done_ready) begin
      hold_q <= 1'b0;
      last_q <= done_idx; // next search starts after this one
    end else if (done_valid) begin
      hold_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (done_valid && !done_ready) hold_idx_q <= done_idx;
  end

endmodule

/* design/dispatch_regs.sv */
`timescale 1ns/1ns

module dispatch_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cfg_valid,  // mask write strobe
  input  cpu_block_pkg::cell_mask_t  cfg_mask,
  input  logic                       done_fire,  // result handshake
  output cpu_block_pkg::cell_mask_t  enable,
  output cpu_block_pkg::data_t       jobs_done
);

  import cpu_block_pkg::*;

  cell_mask_t enable_q;
  data_t      jobs_done_q;

  // enable mask, all cells on after reset
  // a cleared bit only blocks new jobs at the dispatcher
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable_q <= '1;
    end else if (cfg_valid) begin
      enable_q <= cfg_mask;
    end
  end

  // completed job count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      jobs_done_q <= '0;
    end else if (done_fire) begin
      jobs_done_q <= jobs_done_q + data_t'(1); // wraps
    end
  end

  assign enable    = enable_q;
  assign jobs_done = jobs_done_q;

endmodule

/* design/cpu_block.sv */
`timescale 1ns/1ns
`include "cpu_block_defines.svh"

module cpu_block (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       job_valid,
  output logic                       job_ready,
  input  cpu_block_pkg::addr_t       job_base,
  input  cpu_block_pkg::len_t        job_len,
  output logic                       done_valid,
  input  logic                       done_ready,
  output cpu_block_pkg::cell_idx_t   done_cell,
  output cpu_block_pkg::data_t       done_sum,
  output logic                       mem_valid,
  input  logic                       mem_ready,
  output logic                       mem_we,
  output cpu_block_pkg::addr_t       mem_addr,
  output cpu_block_pkg::data_t       mem_wdata,
  input  logic                       mem_rsp_valid,
  input  cpu_block_pkg::data_t       mem_rsp_data,
  input  logic                       cfg_valid,
  input  cpu_block_pkg::cell_mask_t  cfg_mask,
  output cpu_block_pkg::data_t       jobs_done
);

  import cpu_block_pkg::*;

  cell_mask_t                      cell_start;
  addr_t [`CPU_QUANTITY-1:0]       cell_base;
  len_t [`CPU_QUANTITY-1:0]        cell_len;
  cell_mask_t                      cell_busy;
  cell_mask_t                      cell_res_valid;
  cell_mask_t                      cell_res_ready;
  data_t [`CPU_QUANTITY-1:0]       cell_res_sum;
  cell_mask_t                      cell_req_valid;
  cell_mask_t                      cell_req_we;
  addr_t [`CPU_QUANTITY-1:0]       cell_req_addr;
  data_t [`CPU_QUANTITY-1:0]       cell_req_wdata;
  cell_mask_t                      cell_gnt;
  cell_mask_t                      cell_rsp_valid;
  data_t                           cell_rsp_data;  // shared read data
  cell_mask_t                      enable;
  logic                            done_fire;

  assign done_fire = done_valid && done_ready; // counts completed jobs

  for (genvar i = 0; i < `CPU_QUANTITY; i++) begin : g_cell
    cpu_cell u_cell (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (cell_start[i]),
      .base      (cell_base[i]),
      .len       (cell_len[i]),
      .gnt       (cell_gnt[i]),
      .rsp_valid (cell_rsp_valid[i]),
      .rsp_data  (cell_rsp_data),
      .res_ready (cell_res_ready[i]),
      .busy      (cell_busy[i]),
      .req_valid (cell_req_valid[i]),
      .req_we    (cell_req_we[i]),
      .req_addr  (cell_req_addr[i]),
      .req_wdata (cell_req_wdata[i]),
      .res_valid (cell_res_valid[i]),
      .res_sum   (cell_res_sum[i])
    );
  end

  // single memory port shared by all cells
  bus_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (cell_req_valid),
    .req_we        (cell_req_we),
    .req_addr      (cell_req_addr),
    .req_wdata     (cell_req_wdata),
    .mem_ready     (mem_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_data  (mem_rsp_data),
    .gnt           (cell_gnt),
    .rsp_valid     (cell_rsp_valid),
    .rsp_data      (cell_rsp_data),
    .mem_valid     (mem_valid),
    .mem_we        (mem_we),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata)
  );

  job_dispatcher u_dispatcher (
    .clk        (clk),
    .rst_n      (rst_n),
    .job_valid  (job_valid),
    .job_base   (job_base),
    .job_len    (job_len),
    .enable     (enable),
    .busy       (cell_busy),
    .res_valid  (cell_res_valid),
    .res_sum    (cell_res_sum),
    .done_ready (done_ready),
    .job_ready  (job_ready),
    .start      (cell_start),
    .base       (cell_base),
    .len        (cell_len),
    .res_ready  (cell_res_ready),
    .done_valid (done_valid),
    .done_cell  (done_cell),
    .done_sum   (done_sum)
  );

  dispatch_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_valid (cfg_valid),
    .cfg_mask  (cfg_mask),
    .done_fire (done_fire),
    .enable    (enable),
    .jobs_done (jobs_done)
  );

endmodule

/* test/tb_cpu_block.sv */
`timescale 1ns/1ns
`include "cpu_block_defines.svh"

module tb_cpu_block;

  import cpu_block_pkg::*;

  localparam int N_JOBS          = 80;  // all phases together
  localparam int MAX_LEN         = 40;
  localparam int REGION          = 512; // one private memory region per job
  localparam int WATCHDOG_CYCLES = N_JOBS * MAX_LEN * 20;
  localparam int MEM_WORDS       = 1 << `ADDR_SIZE;

  logic        clk;
  logic        rst_n;
  logic        job_valid;
  logic        job_ready;
  addr_t       job_base;
  len_t        job_len;
  logic        done_valid;
  logic        done_ready;
  cell_idx_t   done_cell;
  data_t       done_sum;
  logic        mem_valid;
  logic        mem_ready;
  logic        mem_we;
  addr_t       mem_addr;
  data_t       mem_wdata;
  logic        mem_rsp_valid;
  data_t       mem_rsp_data;
  logic        cfg_valid;
  cell_mask_t  cfg_mask;
  data_t       jobs_done;

  data_t       mem_q [0:MEM_WORDS-1];
  addr_t       wlog_addr [$];              // writes seen by the memory model
  data_t       wlog_data [$];
  addr_t       open_base [$];              // submitted jobs keyed by base
  addr_t       slot_base [`CPU_QUANTITY];  // job held by each cell
  len_t        slot_len [`CPU_QUANTITY];
  data_t       slot_sum [`CPU_QUANTITY];   // reference sum of that job
  cell_mask_t  slot_busy;
  cell_mask_t  exp_mask;
  logic        one_cell_mode;
  cell_idx_t   one_cell;
  logic        bp_en;                      // random done_ready when set
  logic [31:0] stim_q;
  logic [31:0] noise_q;
  int          rsp_wait;                   // cycles until read data goes out
  data_t       rsp_word;
  int          submitted;
  int          results;
  int          next_region;
  string       test_name;

  cpu_block u_cpu_block (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // expected sum over words base to base+len-1 with wrap
  function automatic data_t ref_sum(input addr_t base, input len_t len);
    data_t acc;
    acc = '0;
    for (int k = 0; k < int'(len); k++) begin
      acc = acc + mem_q[addr_t'(int'(base) + k)];
    end
    return acc;
  endfunction

  // lowest idle enabled cell gets the job
  function automatic int lowest_cell(input cell_mask_t free);
    int c;
    c = -1;
    for (int k = 0; k < `CPU_QUANTITY; k++) begin
      if (free[k] && c < 0) c = k;
    end
    return c;
  endfunction

  task automatic report_error(input string why);
    $display("error: %s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_sum(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "sum mismatch");
    end
  endtask

  task automatic check_cell(input string name, input cell_idx_t exp, input cell_idx_t act);
    if (act !== exp) begin
      $display("Fail %s expected %0d actual %0d", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "cell mismatch");
    end
  endtask

  task automatic check_count(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Fail %s expected %0d actual %0d", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "count mismatch");
    end
  endtask

  // memory model with random ready and 1..3 cycle read latency
  always @(posedge clk) begin
    noise_q = xorshift32(noise_q);
    mem_ready     <= noise_q[3] | noise_q[9];   // ready about 3 cycles in 4
    done_ready    <= bp_en ? noise_q[14] : 1'b1;
    mem_rsp_valid <= 1'b0;
    if (rsp_wait == 1) begin
      mem_rsp_valid <= 1'b1;
      mem_rsp_data  <= rsp_word;
    end
    if (rsp_wait > 0) begin
      rsp_wait = rsp_wait - 1;
    end
    if (mem_valid && mem_ready) begin
      if (mem_we) begin
        mem_q[mem_addr] = mem_wdata;
        wlog_addr.push_back(mem_addr);
        wlog_data.push_back(mem_wdata);
      end else begin
        rsp_word = mem_q[mem_addr];
        rsp_wait = 1 + int'(noise_q[25:24] % 3);
      end
    end
  end

  task automatic record_job();
    int c;
    c = lowest_cell(exp_mask & ~slot_busy);
    if (c < 0) begin
      report_error("job accepted while no enabled cell was idle");
    end else begin
      slot_busy[c] = 1'b1;
      slot_base[c] = job_base;
      slot_len[c]  = job_len;
      slot_sum[c]  = ref_sum(job_base, job_len);  // private region keeps the data stable
      open_base.push_back(job_base);
    end
  endtask

  task automatic score_result();
    int    c;
    int    w;
    int    q;
    addr_t wb_addr;
    c = int'(done_cell);
    w = -1;
    q = -1;
    if (one_cell_mode) check_cell(test_name, one_cell, done_cell);
    if (!exp_mask[c]) report_error("result came from a disabled cell");
    for (int k = 0; k < open_base.size(); k++) begin
      if (open_base[k] == slot_base[c]) q = k;
    end
    if (q < 0) begin
      report_error("result for a job that was never submitted or already reported");
    end else begin
      open_base.delete(q);
    end
    check_sum(test_name, slot_sum[c], done_sum);
    wb_addr = slot_base[c] + addr_t'(slot_len[c]);   // sum lands after the data
    for (int k = 0; k < wlog_addr.size(); k++) begin
      if (wlog_addr[k] == wb_addr) w = k;
    end
    if (w < 0) begin
      report_error("no write of the sum seen at base plus len");
    end else begin
      check_sum({test_name, "_writeback"}, slot_sum[c], wlog_data[w]);
      wlog_addr.delete(w);
      wlog_data.delete(w);
    end
    slot_busy[c] = 1'b0;
    results++;
  endtask

  // job side first so a cell freed this edge is not reused
  always @(posedge clk) begin
    if (job_valid && job_ready) begin
      record_job();
    end
    if (done_valid && done_ready) begin
      score_result();
    end
  end

  task automatic run_jobs(input int count, input int zero_every);
    addr_t b;
    len_t  l;
    for (int j = 0; j < count; j++) begin
      stim_q = xorshift32(stim_q);
      b = addr_t'(next_region * REGION + int'(stim_q[7:0]));
      l = len_t'(int'(stim_q[31:16]) % (MAX_LEN + 1));
      if (zero_every > 0 && j % zero_every == 0) l = '0;  // empty jobs too
      next_region++;
      job_valid <= 1'b1;
      job_base  <= b;
      job_len   <= l;
      do @(posedge clk); while (!job_ready);
      submitted++;
    end
    job_valid <= 1'b0;
  endtask

  // sample the counters away from the rising edge
  task automatic wait_all();
    while (results != submitted) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic set_mask(input cell_mask_t m);
    cfg_valid <= 1'b1;
    cfg_mask  <= m;
    @(posedge clk);    // mask loads here
    cfg_valid <= 1'b0;
    exp_mask = m;
  endtask

  initial begin
    rst_n         = 1'b0;
    job_valid     = 1'b0;
    job_base      = '0;
    job_len       = '0;
    done_ready    = 1'b0;
    mem_ready     = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rsp_data  = '0;
    cfg_valid     = 1'b0;
    cfg_mask      = '0;
    slot_busy     = '0;
    exp_mask      = '1;   // all cells on out of reset
    one_cell_mode = 1'b0;
    one_cell      = '0;
    bp_en         = 1'b0;
    rsp_wait      = 0;
    rsp_word      = '0;
    submitted     = 0;
    results       = 0;
    next_region   = 0;
    test_name     = "reset";
    stim_q        = 32'he2b5;
    noise_q       = 32'he2b5;
    for (int a = 0; a < MEM_WORDS; a++) begin
      stim_q   = xorshift32(stim_q);
      mem_q[a] = stim_q;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (done_valid !== 1'b0 || mem_valid !== 1'b0) begin
      report_error("done_valid or mem_valid not low after reset");
    end
    check_count(test_name, '0, jobs_done);

    test_name = "sum_check";
    run_jobs(24, 6);
    wait_all();

    test_name = "one_cell";
    set_mask(cell_mask_t'(4'b0100));
    one_cell      = cell_idx_t'(2);
    one_cell_mode = 1'b1;
    run_jobs(8, 0);
    wait_all();
    one_cell_mode = 1'b0;

    test_name = "subset_mask";
    set_mask(cell_mask_t'(4'b1010));
    run_jobs(8, 4);
    wait_all();
    set_mask('1);

    test_name = "back_pressure";
    bp_en = 1'b1;
    run_jobs(40, 7);   // all cells loaded while the result port stalls
    wait_all();
    bp_en = 1'b0;

    test_name = "job_count";
    check_count(test_name, data_t'(submitted), jobs_done);
    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_error("timeout, jobs still running when the watchdog expired");
  end

endmodule

/* cpu_block.f */
+incdir+design
design/cpu_block_pkg.sv
design/cpu_cell.sv
design/bus_arbiter.sv
design/job_dispatcher.sv
design/dispatch_regs.sv
design/cpu_block.sv
test/tb_cpu_block.sv

/* Bender.yml */
package:
  name: cpu_block

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_block_pkg.sv
      - design/cpu_cell.sv
      - design/bus_arbiter.sv
      - design/job_dispatcher.sv
      - design/dispatch_regs.sv
      - design/cpu_block.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_cpu_block.sv
